// File: zmips_pkg.sv
// Shared zmips encodings. ALU codes 6 and 7 are reserved and give zero, and JAL, JR and LI are absent
package zmips_pkg;

    typedef logic [31:0] word_t;                // Data or address word
    typedef logic [4:0]  reg_addr_t;            // Register number

    // ALU operation, funct bits 5:3
    typedef enum logic [2:0]
    {
        alu_and = 3'd0,
        alu_or  = 3'd1,
        alu_xor = 3'd2,
        alu_add = 3'd3,
        alu_sub = 3'd4,                         // Carry set when no borrow
        alu_nor = 3'd5
    } alu_op_e;

    // Shift applied to the A operand, op bits 1:0
    typedef enum logic [1:0]
    {
        shift_none = 2'd0,
        shift_sll  = 2'd1,
        shift_srl  = 2'd2,
        shift_sra  = 2'd3
    } shift_op_e;

    // Operand source in EX
    typedef enum logic [1:0]
    {
        fwd_rf     = 2'd0,                      // Value read in ID
        fwd_wb     = 2'd1,                      // MEM/WB writeback data
        fwd_ex_mem = 2'd2                       // EX/MEM ALU result
    } fwd_sel_e;

    // One instruction word seen as R, I and J layouts
    typedef union packed
    {
        struct packed
        {
            logic [5:0] op;
            reg_addr_t  rs;
            reg_addr_t  rt;
            reg_addr_t  rd;
            logic [4:0] shamt;
            logic [5:0] funct;                  // Bits 2:0 enable N, C, Z updates
        } r_fmt;
        struct packed
        {
            logic [3:0]  op;                    // 10xx is a branch
            logic [1:0]  cc;                    // Z, C, N or always
            logic [25:0] imm;                   // Word offset from PC+4
        } i_fmt;
        struct packed
        {
            logic [1:0]  op;                    // 11 is a jump
            logic [29:0] addr;                  // Word address
        } j_fmt;
    } instr_t;

    localparam int op_wb_bit   = 2;             // R op, write back to rd
    localparam int op_mem_bit  = 3;             // R op, load or store
    localparam int op_load_bit = 2;             // R op with mem set, 1 = load
    localparam int i_set_bit   = 1;             // I op, branch on set
    localparam logic [1:0] cc_always = 2'b11;

endpackage

// File: zmips_id_ex_if.sv
// ID/EX register contents. Decode owns the register and execute returns the live flags for branches
`timescale 1ns/1ps
interface zmips_id_ex_if;

    zmips_pkg::word_t     rs_data;
    zmips_pkg::word_t     rt_data;
    zmips_pkg::reg_addr_t rs_addr;
    zmips_pkg::reg_addr_t rt_addr;              // Also checked for load-use
    zmips_pkg::reg_addr_t rd_addr;              // Destination, rt for loads
    zmips_pkg::word_t     offset;               // Sign-extended bits 15:0
    logic [4:0]           shamt;
    zmips_pkg::shift_op_e shift_op;
    zmips_pkg::alu_op_e   alu_op;
    logic                 use_imm;              // B operand from offset
    logic                 mem_rd;
    logic                 mem_wr;
    logic                 wr_reg;
    logic                 wr_zf;                // Flag update enables
    logic                 wr_cf;
    logic                 wr_nf;
    logic                 zf_fwd;               // Flags as seen by ID this cycle
    logic                 cf_fwd;
    logic                 nf_fwd;

    modport decode
    (
        output rs_data, rt_data, rs_addr, rt_addr, rd_addr, offset, shamt, shift_op, alu_op,
        output use_imm, mem_rd, mem_wr, wr_reg, wr_zf, wr_cf, wr_nf,
        input  zf_fwd, cf_fwd, nf_fwd
    );

    modport execute
    (
        input  rs_data, rt_data, rs_addr, rt_addr, rd_addr, offset, shamt, shift_op, alu_op,
        input  use_imm, mem_rd, mem_wr, wr_reg, wr_zf, wr_cf, wr_nf,
        output zf_fwd, cf_fwd, nf_fwd
    );

endinterface

// File: zmips_ex_mem_if.sv
// EX/MEM register contents. The result doubles as the data memory address
`timescale 1ns/1ps
interface zmips_ex_mem_if;

    zmips_pkg::word_t     result;               // ALU output or memory address
    zmips_pkg::word_t     store_data;           // Forwarded rt
    zmips_pkg::reg_addr_t rd_addr;
    logic                 mem_rd;
    logic                 mem_wr;
    logic                 wr_reg;

    modport execute
    (
        output result, store_data, rd_addr, mem_rd, mem_wr, wr_reg
    );

    modport mem_wb
    (
        input result, store_data, rd_addr, mem_rd, mem_wr, wr_reg
    );

endinterface

// File: zmips_regfile.sv
// Two async reads with write-through from WB. r0 is hardwired to zero and reset clears the rest
`timescale 1ns/1ps
module zmips_regfile
(
    input  logic                 clk,
    input  logic                 rst,
    input  zmips_pkg::reg_addr_t rs_addr,
    input  zmips_pkg::reg_addr_t rt_addr,
    input  zmips_pkg::reg_addr_t wb_addr,
    input  zmips_pkg::word_t     wb_data,
    input  logic                 wb_wr,
    output zmips_pkg::word_t     rs_data,
    output zmips_pkg::word_t     rt_data
);

    zmips_pkg::word_t regs [1:31];              // No storage for r0

    // Read port with bypass of the write in flight
    function automatic zmips_pkg::word_t read_port(zmips_pkg::reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (wb_wr && wb_addr == addr)
            return wb_data;
        return regs[addr];
    endfunction

    assign rs_data = read_port(rs_addr);
    assign rt_data = read_port(rt_addr);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wb_wr && wb_addr != '0)
            regs[wb_addr] <= wb_data;           // Writes to r0 are dropped
    end

    // A writeback aimed at r0 must not show up on a later read
    r0_stays_zero: assert property (@(posedge clk) disable iff (rst)
        (wb_wr && wb_addr == '0) |=> (rs_addr != '0 || rs_data == '0));

endmodule

// File: zmips_alu.sv
// Shift of A by shamt comes first. Carry is defined only for add and sub and reserved ops give zero
`timescale 1ns/1ps
module zmips_alu
(
    input  zmips_pkg::word_t     a,
    input  zmips_pkg::word_t     b,
    input  logic [4:0]           shamt,
    input  zmips_pkg::shift_op_e shift_op,
    input  zmips_pkg::alu_op_e   op,
    output zmips_pkg::word_t     y,
    output logic                 zf,
    output logic                 cf,
    output logic                 nf
);

    zmips_pkg::word_t a_sh;                     // A after the barrel shifter
    logic [32:0]      sum;                      // Adder with carry out

    always_comb
    begin
        case (shift_op)
            zmips_pkg::shift_sll: a_sh = a << shamt;
            zmips_pkg::shift_srl: a_sh = a >> shamt;
            zmips_pkg::shift_sra: a_sh = $signed(a) >>> shamt;  // Keeps sign
            default:              a_sh = a;
        endcase
    end

    // Sub is A + ~B + 1 so the carry reads as no borrow
    assign sum = (op == zmips_pkg::alu_sub) ? {1'b0, a_sh} + {1'b0, ~b} + 33'd1
                                            : {1'b0, a_sh} + {1'b0, b};

    always_comb
    begin
        cf = 1'b0;
        case (op)
            zmips_pkg::alu_and: y = a_sh & b;
            zmips_pkg::alu_or:  y = a_sh | b;
            zmips_pkg::alu_xor: y = a_sh ^ b;
            zmips_pkg::alu_nor: y = ~(a_sh | b);
            zmips_pkg::alu_add,
            zmips_pkg::alu_sub:
            begin
                y  = sum[31:0];
                cf = sum[32];
            end
            default:            y = '0;         // Codes 6 and 7
        endcase
    end

    assign zf = (y == '0);
    assign nf = y[31];                          // Sign of the result

endmodule

// File: zmips_fetch.sv
// PC and IF/ID. Stall holds both, redirect loads the target and flushes IF/ID to a no-op
`timescale 1ns/1ps
module zmips_fetch
#(
    parameter zmips_pkg::word_t reset_pc = '0
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              redirect,
    input  zmips_pkg::word_t  redirect_pc,
    input  zmips_pkg::word_t  i_data,
    output zmips_pkg::word_t  i_addr,
    output zmips_pkg::instr_t if_id_instr,
    output zmips_pkg::word_t  if_id_pc_plus4
);

    zmips_pkg::word_t pc;
    zmips_pkg::word_t pc_plus4;

    assign pc_plus4 = pc + 32'd4;
    assign i_addr   = pc;                       // Instruction memory answers this cycle

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc          <= reset_pc;
            if_id_instr <= '0;
        end
        else if (redirect)
        begin
            pc          <= redirect_pc;
            if_id_instr <= '0;                  // All-zero word does nothing
        end
        else if (!stall)
        begin
            pc          <= pc_plus4;
            if_id_instr <= i_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!stall)
            if_id_pc_plus4 <= pc_plus4;         // Branch base for ID
    end

    // Decode only stalls R-format and only redirects on I or J
    stall_redirect_excl: assert property (@(posedge clk) disable iff (rst)
        !(stall && redirect));

endmodule

// File: zmips_decode.sv
// Branches resolve here with flags from EX. A load in EX whose rt is used by an R-format costs one bubble
`timescale 1ns/1ps
module zmips_decode
(
    input  logic                 clk,
    input  logic                 rst,
    input  zmips_pkg::instr_t    if_id_instr,
    input  zmips_pkg::word_t     if_id_pc_plus4,
    input  zmips_pkg::reg_addr_t wb_addr,
    input  zmips_pkg::word_t     wb_data,
    input  logic                 wb_wr,
    output logic                 stall,
    output logic                 redirect,
    output zmips_pkg::word_t     redirect_pc,
    zmips_id_ex_if.decode        id_ex
);

    zmips_pkg::word_t rs_data;
    zmips_pkg::word_t rt_data;
    zmips_pkg::word_t br_target;
    logic             is_r;
    logic             is_i;
    logic             is_j;
    logic             is_mem;
    logic             is_load;
    logic             br_flag;                  // Flag picked by cc
    logic             br_taken;

    zmips_regfile regfile_inst
    (
        .clk     (clk),
        .rst     (rst),
        .rs_addr (if_id_instr.r_fmt.rs),
        .rt_addr (if_id_instr.r_fmt.rt),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .wb_wr   (wb_wr),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    // Top two bits give the format
    assign is_r    = ~if_id_instr.j_fmt.op[1];
    assign is_i    = (if_id_instr.j_fmt.op == 2'b10);
    assign is_j    = (if_id_instr.j_fmt.op == 2'b11);
    assign is_mem  = if_id_instr.r_fmt.op[zmips_pkg::op_mem_bit];
    assign is_load = is_mem & if_id_instr.r_fmt.op[zmips_pkg::op_load_bit];

    always_comb
    begin
        case (if_id_instr.i_fmt.cc)
            2'b00:   br_flag = id_ex.zf_fwd;
            2'b01:   br_flag = id_ex.cf_fwd;
            2'b10:   br_flag = id_ex.nf_fwd;
            default: br_flag = 1'b1;
        endcase
    end

    assign br_taken = (if_id_instr.i_fmt.cc == zmips_pkg::cc_always)
                    | (br_flag == if_id_instr.i_fmt.op[zmips_pkg::i_set_bit]);

    // Word offset relative to PC+4
    assign br_target = if_id_pc_plus4
                     + {{4{if_id_instr.i_fmt.imm[25]}}, if_id_instr.i_fmt.imm, 2'b00};

    assign redirect    = is_j | (is_i & br_taken);
    assign redirect_pc = is_j ? {if_id_instr.j_fmt.addr, 2'b00} : br_target;

    // Load result not ready until it leaves MEM
    assign stall = is_r & id_ex.mem_rd
                 & (id_ex.rt_addr == if_id_instr.r_fmt.rs
                    | id_ex.rt_addr == if_id_instr.r_fmt.rt);

    always_ff @(posedge clk)
    begin
        id_ex.rs_data  <= rs_data;
        id_ex.rt_data  <= rt_data;
        id_ex.rs_addr  <= if_id_instr.r_fmt.rs;
        id_ex.rt_addr  <= if_id_instr.r_fmt.rt;
        id_ex.rd_addr  <= is_load ? if_id_instr.r_fmt.rt : if_id_instr.r_fmt.rd;
        id_ex.offset   <= {{16{if_id_instr.r_fmt.rd[4]}}, if_id_instr.r_fmt.rd,
                           if_id_instr.r_fmt.shamt, if_id_instr.r_fmt.funct};
        id_ex.shamt    <= if_id_instr.r_fmt.shamt;
        id_ex.shift_op <= zmips_pkg::shift_op_e'(if_id_instr.r_fmt.op[1:0]);
        // Address add for loads and stores
        id_ex.alu_op   <= is_mem ? zmips_pkg::alu_add
                                 : zmips_pkg::alu_op_e'(if_id_instr.r_fmt.funct[5:3]);
        if (rst || stall || !is_r)               // Bubble
        begin
            id_ex.use_imm <= 1'b0;
            id_ex.mem_rd  <= 1'b0;
            id_ex.mem_wr  <= 1'b0;
            id_ex.wr_reg  <= 1'b0;
            id_ex.wr_zf   <= 1'b0;
            id_ex.wr_cf   <= 1'b0;
            id_ex.wr_nf   <= 1'b0;
        end
        else
        begin
            id_ex.use_imm <= is_mem;
            id_ex.mem_rd  <= is_load;
            id_ex.mem_wr  <= is_mem & ~is_load;
            id_ex.wr_reg  <= is_mem ? is_load : if_id_instr.r_fmt.op[zmips_pkg::op_wb_bit];
            id_ex.wr_zf   <= ~is_mem & if_id_instr.r_fmt.funct[0];  // Offset bits are not enables
            id_ex.wr_cf   <= ~is_mem & if_id_instr.r_fmt.funct[1];
            id_ex.wr_nf   <= ~is_mem & if_id_instr.r_fmt.funct[2];
        end
    end

endmodule

// File: zmips_execute.sv
// Forwards from EX/MEM before MEM/WB. Holds the Z, C and N flags and feeds them back to ID
`timescale 1ns/1ps
module zmips_execute
(
    input  logic                 clk,
    input  logic                 rst,
    input  zmips_pkg::reg_addr_t wb_addr,
    input  zmips_pkg::word_t     wb_data,
    input  logic                 wb_wr,
    zmips_id_ex_if.execute       id_ex,
    zmips_ex_mem_if.execute      ex_mem
);

    zmips_pkg::fwd_sel_e rs_sel;
    zmips_pkg::fwd_sel_e rt_sel;
    zmips_pkg::word_t    a_fwd;                 // Forwarded rs
    zmips_pkg::word_t    b_fwd;                 // Forwarded rt, also store data
    zmips_pkg::word_t    alu_b;
    zmips_pkg::word_t    alu_y;
    logic                alu_zf;
    logic                alu_cf;
    logic                alu_nf;
    logic                flag_z;
    logic                flag_c;
    logic                flag_n;

    // Youngest producer wins and r0 never forwards
    function automatic zmips_pkg::fwd_sel_e fwd_pick(zmips_pkg::reg_addr_t src);
        if (src == '0)
            return zmips_pkg::fwd_rf;
        if (ex_mem.wr_reg && ex_mem.rd_addr == src)
            return zmips_pkg::fwd_ex_mem;
        if (wb_wr && wb_addr == src)
            return zmips_pkg::fwd_wb;
        return zmips_pkg::fwd_rf;
    endfunction

    function automatic zmips_pkg::word_t fwd_mux(zmips_pkg::fwd_sel_e sel,
                                                 zmips_pkg::word_t rf_data);
        case (sel)
            zmips_pkg::fwd_ex_mem: return ex_mem.result;
            zmips_pkg::fwd_wb:     return wb_data;
            default:               return rf_data;
        endcase
    endfunction

    assign rs_sel = fwd_pick(id_ex.rs_addr);
    assign rt_sel = fwd_pick(id_ex.rt_addr);
    assign a_fwd  = fwd_mux(rs_sel, id_ex.rs_data);
    assign b_fwd  = fwd_mux(rt_sel, id_ex.rt_data);
    assign alu_b  = id_ex.use_imm ? id_ex.offset : b_fwd;

    zmips_alu alu_inst
    (
        .a        (a_fwd),
        .b        (alu_b),
        .shamt    (id_ex.shamt),
        .shift_op (id_ex.shift_op),
        .op       (id_ex.alu_op),
        .y        (alu_y),
        .zf       (alu_zf),
        .cf       (alu_cf),
        .nf       (alu_nf)
    );

    // Branch right behind a flag update sees the new value
    assign id_ex.zf_fwd = id_ex.wr_zf ? alu_zf : flag_z;
    assign id_ex.cf_fwd = id_ex.wr_cf ? alu_cf : flag_c;
    assign id_ex.nf_fwd = id_ex.wr_nf ? alu_nf : flag_n;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            flag_z <= 1'b0;
            flag_c <= 1'b0;
            flag_n <= 1'b0;
        end
        else
        begin
            flag_z <= id_ex.zf_fwd;             // Keeps old value when not enabled
            flag_c <= id_ex.cf_fwd;
            flag_n <= id_ex.nf_fwd;
        end
    end

    always_ff @(posedge clk)
    begin
        ex_mem.result     <= alu_y;
        ex_mem.store_data <= b_fwd;
        ex_mem.rd_addr    <= id_ex.rd_addr;
        if (rst)
        begin
            ex_mem.mem_rd <= 1'b0;
            ex_mem.mem_wr <= 1'b0;
            ex_mem.wr_reg <= 1'b0;
        end
        else
        begin
            ex_mem.mem_rd <= id_ex.mem_rd;
            ex_mem.mem_wr <= id_ex.mem_wr;
            ex_mem.wr_reg <= id_ex.wr_reg;
        end
    end

    // Decode never builds a load that also stores
    no_rd_with_wr: assert property (@(posedge clk) disable iff (rst)
        !(ex_mem.mem_rd && ex_mem.mem_wr));

endmodule

// File: zmips_mem_wb.sv
// Data memory strobes come straight from EX/MEM and read data must be valid in the same cycle
`timescale 1ns/1ps
module zmips_mem_wb
(
    input  logic                 clk,
    input  logic                 rst,
    input  zmips_pkg::word_t     d_rdata,
    output zmips_pkg::word_t     d_addr,
    output zmips_pkg::word_t     d_wdata,
    output logic                 d_rd,
    output logic                 d_wr,
    output zmips_pkg::reg_addr_t wb_addr,
    output zmips_pkg::word_t     wb_data,
    output logic                 wb_wr,
    zmips_ex_mem_if.mem_wb       ex_mem
);

    zmips_pkg::word_t mem_data;                 // Loaded word
    zmips_pkg::word_t alu_data;
    logic             wb_load;                  // Pick mem_data for writeback

    assign d_addr  = ex_mem.result;
    assign d_wdata = ex_mem.store_data;
    assign d_rd    = ex_mem.mem_rd;
    assign d_wr    = ex_mem.mem_wr;

    always_ff @(posedge clk)
    begin
        mem_data <= d_rdata;
        alu_data <= ex_mem.result;
        wb_addr  <= ex_mem.rd_addr;
        if (rst)
        begin
            wb_wr   <= 1'b0;
            wb_load <= 1'b0;
        end
        else
        begin
            wb_wr   <= ex_mem.wr_reg;
            wb_load <= ex_mem.mem_rd;
        end
    end

    assign wb_data = wb_load ? mem_data : alu_data;  // Also the WB forward source

endmodule

// File: zmips.sv
// Five-stage zmips core on one rising clock. Memories answer combinationally and nothing back-pressures
`timescale 1ns/1ps
module zmips
#(
    parameter zmips_pkg::word_t reset_pc = '0
)
(
    input  logic             clk,
    input  logic             rst,               // Synchronous, active high
    output zmips_pkg::word_t i_addr,
    input  zmips_pkg::word_t i_data,
    output zmips_pkg::word_t d_addr,
    output zmips_pkg::word_t d_wdata,
    input  zmips_pkg::word_t d_rdata,
    output logic             d_rd,
    output logic             d_wr
);

    logic                 stall;
    logic                 redirect;
    zmips_pkg::word_t     redirect_pc;
    zmips_pkg::instr_t    if_id_instr;
    zmips_pkg::word_t     if_id_pc_plus4;
    zmips_pkg::reg_addr_t wb_addr;              // Writeback bus to ID and EX
    zmips_pkg::word_t     wb_data;
    logic                 wb_wr;

    zmips_id_ex_if  id_ex ();
    zmips_ex_mem_if ex_mem ();

    zmips_fetch #(.reset_pc(reset_pc)) fetch_inst
    (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .i_data         (i_data),
        .i_addr         (i_addr),
        .if_id_instr    (if_id_instr),
        .if_id_pc_plus4 (if_id_pc_plus4)
    );

    zmips_decode decode_inst
    (
        .clk            (clk),
        .rst            (rst),
        .if_id_instr    (if_id_instr),
        .if_id_pc_plus4 (if_id_pc_plus4),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .wb_wr          (wb_wr),
        .stall          (stall),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .id_ex          (id_ex.decode)
    );

    zmips_execute execute_inst
    (
        .clk     (clk),
        .rst     (rst),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .wb_wr   (wb_wr),
        .id_ex   (id_ex.execute),
        .ex_mem  (ex_mem.execute)
    );

    zmips_mem_wb mem_wb_inst
    (
        .clk     (clk),
        .rst     (rst),
        .d_rdata (d_rdata),
        .d_addr  (d_addr),
        .d_wdata (d_wdata),
        .d_rd    (d_rd),
        .d_wr    (d_wr),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .wb_wr   (wb_wr),
        .ex_mem  (ex_mem.mem_wb)
    );

endmodule

// File: zmips_checker.sv
// Watches the data port on the falling edge. Expected stores must be loaded before reset is released
`timescale 1ns/1ps
module zmips_checker
(
    input  logic             clk,
    input  logic             rst,
    input  zmips_pkg::word_t d_addr,
    input  zmips_pkg::word_t d_wdata,
    input  logic             d_rd,
    input  logic             d_wr,
    output logic             done,             // Every expected store seen
    output int               mismatch_count,
    output int               other_count
);

    zmips_pkg::word_t exp_addr [$];
    zmips_pkg::word_t exp_data [$];
    int               n_expected = 0;
    int               store_idx = 0;           // Next table entry
    int               n_mismatch = 0;
    int               n_other = 0;
    int               cyc = 0;                 // Rising edges since reset release

    assign done           = (n_expected > 0) && (store_idx == n_expected);
    assign mismatch_count = n_mismatch;
    assign other_count    = n_other;

    task automatic add_expected_store(input zmips_pkg::word_t addr,
                                      input zmips_pkg::word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        n_expected = n_expected + 1;
    endtask

    always @(posedge clk)
    begin
        if (rst)
            cyc <= 0;
        else
            cyc <= cyc + 1;
    end

    always @(negedge clk)
    begin
        // First load is fetched on edge 1 and sits in MEM after edge 3
        if ((rst || cyc < 3) && (d_rd !== 1'b0 || d_wr !== 1'b0))
        begin
            $display("Memory strobe active at %0t before the first load could reach MEM", $time);
            n_other = n_other + 1;
        end
        if (!rst && cyc == 3 && d_rd !== 1'b1)
        begin
            $display("The first load did not reach MEM three cycles after reset (%0t)", $time);
            n_other = n_other + 1;
        end
        if (d_rd === 1'b1 && d_wr === 1'b1)
        begin
            $display("Load and store strobes active together at %0t", $time);
            n_other = n_other + 1;
        end
        if (d_wr === 1'b1)
        begin
            if (store_idx >= n_expected)
            begin
                $display("Store beyond the expected table at %0t, address %h data %h",
                         $time, d_addr, d_wdata);
                n_other = n_other + 1;
            end
            else
            begin
                if (d_addr !== exp_addr[store_idx] || d_wdata !== exp_data[store_idx])
                begin
                    $display("Mismatch at %0t: store %0d wrote %h to %h, expected %h to %h",
                             $time, store_idx, d_wdata, d_addr,
                             exp_data[store_idx], exp_addr[store_idx]);
                    n_mismatch = n_mismatch + 1;
                end
                store_idx <= store_idx + 1;    // Seen by the run loop one edge later
            end
        end
    end

endmodule

// File: tb_zmips.sv
// Program starts at reset_pc 0x100 and data memory is 64 words, so only d_addr bits 7:2 decode
`timescale 1ns/1ps
module tb_zmips;

    localparam zmips_pkg::word_t reset_pc = 32'h0000_0100;
    localparam int max_cycles = 500;            // Whole program needs far fewer
    localparam int n_stores = 17;

    // ALU and shift codes
    localparam logic [2:0] op_and = 3'd0;
    localparam logic [2:0] op_or  = 3'd1;
    localparam logic [2:0] op_xor = 3'd2;
    localparam logic [2:0] op_add = 3'd3;
    localparam logic [2:0] op_sub = 3'd4;
    localparam logic [2:0] op_nor = 3'd5;
    localparam logic [1:0] sh_none = 2'd0;
    localparam logic [1:0] sh_sll  = 2'd1;
    localparam logic [1:0] sh_srl  = 2'd2;
    localparam logic [1:0] sh_sra  = 2'd3;

    logic             clk = 1'b0;               // Starts low with no edge at time zero
    logic             rst;
    zmips_pkg::word_t i_addr;
    zmips_pkg::word_t i_data;
    zmips_pkg::word_t d_addr;
    zmips_pkg::word_t d_wdata;
    zmips_pkg::word_t d_rdata;
    logic             d_rd;
    logic             d_wr;
    logic             done;
    int               mismatch_count;
    int               other_count;

    zmips_pkg::word_t prog [64];
    zmips_pkg::word_t dmem [64];
    zmips_pkg::word_t exp_addr_tab [n_stores];
    zmips_pkg::word_t exp_data_tab [n_stores];
    zmips_pkg::word_t fetch_idx;
    integer           seed;
    int               tb_errors;
    int               cycles;

    zmips #(.reset_pc(reset_pc)) zmips_inst
    (
        .clk     (clk),
        .rst     (rst),
        .i_addr  (i_addr),
        .i_data  (i_data),
        .d_addr  (d_addr),
        .d_wdata (d_wdata),
        .d_rdata (d_rdata),
        .d_rd    (d_rd),
        .d_wr    (d_wr)
    );

    zmips_checker checker_inst
    (
        .clk            (clk),
        .rst            (rst),
        .d_addr         (d_addr),
        .d_wdata        (d_wdata),
        .d_rd           (d_rd),
        .d_wr           (d_wr),
        .done           (done),
        .mismatch_count (mismatch_count),
        .other_count    (other_count)
    );

    always #20 clk = ~clk;

    // Both memories answer on the falling edge, ahead of the next rising edge
    always @(negedge clk)
    begin
        fetch_idx = (i_addr - reset_pc) >> 2;
        i_data <= (fetch_idx < 64) ? prog[fetch_idx] : '0;  // Outside the table is a no-op
        d_rdata <= dmem[d_addr[7:2]];
        if (d_wr === 1'b1)
            dmem[d_addr[7:2]] <= d_wdata;
    end

    // R format {00, mem, wb, shift}, rs, rt, rd, shamt, {alu op, N C Z enables}
    function automatic zmips_pkg::word_t alu_instr(input logic wb, input logic [1:0] sh,
        input logic [4:0] rs, rt, rd, shamt, input logic [2:0] op, input logic [2:0] fen);
        return {3'b000, wb, sh, rs, rt, rd, shamt, op, fen};
    endfunction

    function automatic zmips_pkg::word_t load_instr(input logic [4:0] rt, input logic [15:0] off);
        return {6'b001100, 5'd0, rt, off};     // Base is r0
    endfunction

    function automatic zmips_pkg::word_t store_instr(input logic [4:0] rt, input logic [15:0] off);
        return {6'b001000, 5'd0, rt, off};
    endfunction

    // cc 0 Z, 1 C, 2 N, 3 always
    function automatic zmips_pkg::word_t branch_instr(input logic set, input logic [1:0] cc,
                                                      input logic [25:0] imm);
        return {2'b10, set, 1'b0, cc, imm};
    endfunction

    function automatic zmips_pkg::word_t jump_instr(input logic [29:0] idx);
        return {2'b11, reset_pc[31:2] + idx};  // Absolute word address of table entry
    endfunction

    task automatic load_program();
        prog[0]  = load_instr(5'd1, 16'h0000);
        prog[1]  = load_instr(5'd2, 16'h0004);
        prog[2]  = alu_instr(1'b1, sh_none, 5'd1, 5'd2, 5'd3, 5'd0, op_add, 3'b000); // Load-use
        prog[3]  = store_instr(5'd3, 16'h0080);
        prog[4]  = alu_instr(1'b1, sh_none, 5'd1, 5'd2, 5'd4, 5'd0, op_and, 3'b000);
        prog[5]  = alu_instr(1'b1, sh_none, 5'd4, 5'd1, 5'd5, 5'd0, op_or, 3'b000);
        prog[6]  = alu_instr(1'b1, sh_none, 5'd5, 5'd2, 5'd6, 5'd0, op_xor, 3'b000);
        prog[7]  = alu_instr(1'b1, sh_none, 5'd6, 5'd1, 5'd7, 5'd0, op_sub, 3'b000);
        prog[8]  = alu_instr(1'b1, sh_none, 5'd7, 5'd4, 5'd8, 5'd0, op_nor, 3'b000);
        prog[9]  = store_instr(5'd4, 16'h0084);
        prog[10] = store_instr(5'd5, 16'h0088);
        prog[11] = store_instr(5'd6, 16'h008c);
        prog[12] = store_instr(5'd7, 16'h0090);
        prog[13] = store_instr(5'd8, 16'h0094);
        prog[14] = alu_instr(1'b0, sh_none, 5'd1, 5'd1, 5'd4, 5'd0, op_add, 3'b000); // No wb
        prog[15] = alu_instr(1'b1, sh_none, 5'd1, 5'd2, 5'd0, 5'd0, op_add, 3'b000); // To r0
        prog[16] = alu_instr(1'b1, sh_none, 5'd0, 5'd2, 5'd9, 5'd0, op_or, 3'b000);
        prog[17] = store_instr(5'd4, 16'h0098);
        prog[18] = store_instr(5'd9, 16'h009c);
        prog[19] = alu_instr(1'b1, sh_sll, 5'd1, 5'd0, 5'd10, 5'd3, op_or, 3'b000);
        prog[20] = alu_instr(1'b1, sh_srl, 5'd1, 5'd0, 5'd11, 5'd7, op_or, 3'b000);
        prog[21] = load_instr(5'd12, 16'h0008);
        prog[22] = alu_instr(1'b1, sh_none, 5'd0, 5'd0, 5'd13, 5'd0, op_nor, 3'b000); // All ones
        prog[23] = alu_instr(1'b1, sh_sll, 5'd13, 5'd12, 5'd14, 5'd31, op_or, 3'b000);
        prog[24] = alu_instr(1'b1, sh_sra, 5'd14, 5'd0, 5'd15, 5'd5, op_or, 3'b000);
        prog[25] = alu_instr(1'b1, sh_sra, 5'd14, 5'd0, 5'd16, 5'd12, op_or, 3'b000);
        prog[26] = store_instr(5'd10, 16'h00a0);
        prog[27] = store_instr(5'd11, 16'h00a4);
        prog[28] = store_instr(5'd14, 16'h00a8);
        prog[29] = store_instr(5'd15, 16'h00ac);
        prog[30] = store_instr(5'd16, 16'h00b0);
        prog[31] = alu_instr(1'b1, sh_none, 5'd1, 5'd1, 5'd17, 5'd0, op_sub, 3'b111); // Z C set
        prog[32] = branch_instr(1'b1, 2'd0, 26'd1);    // Z set, taken
        prog[33] = store_instr(5'd1, 16'h00b4);
        prog[34] = branch_instr(1'b1, 2'd2, 26'd1);    // N set, not taken
        prog[35] = store_instr(5'd2, 16'h00b8);
        prog[36] = alu_instr(1'b1, sh_none, 5'd13, 5'd0, 5'd18, 5'd0, op_add, 3'b100); // N only
        prog[37] = branch_instr(1'b0, 2'd0, 26'd1);    // Z clear, Z kept so not taken
        prog[38] = store_instr(5'd18, 16'h00bc);
        prog[39] = branch_instr(1'b1, 2'd1, 26'd1);    // C set, kept from 31
        prog[40] = store_instr(5'd1, 16'h00c0);
        prog[41] = alu_instr(1'b1, sh_none, 5'd13, 5'd13, 5'd19, 5'd0, op_add, 3'b011);
        prog[42] = branch_instr(1'b0, 2'd1, 26'd1);    // C clear, not taken
        prog[43] = branch_instr(1'b1, 2'd2, 26'd1);    // N still set
        prog[44] = store_instr(5'd1, 16'h00c4);
        prog[45] = branch_instr(1'b1, 2'd0, 26'd1);    // Z now clear
        prog[46] = store_instr(5'd19, 16'h00c8);
        prog[47] = branch_instr(1'b0, 2'd3, 26'd1);    // Always
        prog[48] = store_instr(5'd1, 16'h00cc);
        prog[49] = jump_instr(30'd52);
        prog[50] = store_instr(5'd1, 16'h00d0);
        prog[51] = store_instr(5'd2, 16'h00d4);
        prog[52] = store_instr(5'd3, 16'h00d8);         // Final store
        prog[53] = jump_instr(30'd53);                  // Park here
    endtask

    // Expected stores from the preloaded words 0 to 2
    task automatic build_expected();
        zmips_pkg::word_t m0;
        zmips_pkg::word_t m1;
        zmips_pkg::word_t r4;
        zmips_pkg::word_t r5;
        zmips_pkg::word_t r6;
        zmips_pkg::word_t r7;
        zmips_pkg::word_t r14;
        m0  = dmem[0];
        m1  = dmem[1];
        r4  = m0 & m1;
        r5  = r4 | m0;
        r6  = r5 ^ m1;
        r7  = r6 - m0;
        r14 = 32'h8000_0000 | dmem[2];
        exp_data_tab = '{m0 + m1, r4, r5, r6, r7, ~(r7 | r4), r4, m1, m0 << 3, m0 >> 7, r14,
                         {{5{r14[31]}}, r14[31:5]}, {{12{r14[31]}}, r14[31:12]}, m1,
                         32'hffff_ffff, 32'hffff_fffe, m0 + m1};
        exp_addr_tab = '{32'h80, 32'h84, 32'h88, 32'h8c, 32'h90, 32'h94, 32'h98, 32'h9c,
                         32'ha0, 32'ha4, 32'ha8, 32'hac, 32'hb0, 32'hb8, 32'hbc, 32'hc8,
                         32'hd8};
    endtask

    initial
    begin
        rst       = 1'b1;
        i_data    = '0;
        d_rdata   = '0;
        tb_errors = 0;
        seed      = 32'h8aa6;
        for (int i = 0; i < 64; i++)
        begin
            dmem[i] = $random(seed);
            prog[i] = '0;
        end
        load_program();
        build_expected();
        for (int i = 0; i < n_stores; i++)
            checker_inst.add_expected_store(exp_addr_tab[i], exp_data_tab[i]);

        repeat (5) @(negedge clk);
        rst <= 1'b0;
        if (i_addr !== reset_pc)
        begin
            $display("Mismatch at %0t: i_addr %h after reset, expected %h", $time, i_addr,
                     reset_pc);
            tb_errors++;
        end

        cycles = 0;
        while (done !== 1'b1 && cycles < max_cycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1)
        begin
            $display("Timeout: the program never reached its final store");
            tb_errors++;
        end
        else
            repeat (8) @(negedge clk);          // Catch stray stores after the last one

        $display("Errors: %0d mismatches, %0d other", mismatch_count, other_count + tb_errors);
        if (mismatch_count == 0 && other_count == 0 && tb_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// File: zmips.f
zmips_pkg.sv
zmips_id_ex_if.sv
zmips_ex_mem_if.sv
zmips_regfile.sv
zmips_alu.sv
zmips_fetch.sv
zmips_decode.sv
zmips_execute.sv
zmips_mem_wb.sv
zmips.sv
zmips_checker.sv
tb_zmips.sv

// File: Bender.yml
package:
  name: zmips

sources:
  - zmips_pkg.sv
  - zmips_id_ex_if.sv
  - zmips_ex_mem_if.sv
  - zmips_regfile.sv
  - zmips_alu.sv
  - zmips_fetch.sv
  - zmips_decode.sv
  - zmips_execute.sv
  - zmips_mem_wb.sv
  - zmips.sv
  - target: simulation
    files:
      - zmips_checker.sv
      - tb_zmips.sv
